// File: src/cnn_isa_pkg.sv
package cnn_isa_pkg;

    // host control and status word
    typedef logic [31:0] ctrl_word_t;

    // decoded field types
    typedef logic [7:0]  opcode_t;
    typedef logic [11:0] chan_size_t;
    typedef logic [8:0]  ofmap_dim_t;
    typedef logic [4:0]  kernel_code_t;

    ///////////////////////////////
    // opcodes
    ///////////////////////////////
    localparam opcode_t OP_COMPUTE      = 8'd87;
    localparam opcode_t OP_WRITE_WEIGHT = 8'd12;
    // decodes as neither compute nor write weight
    localparam opcode_t OP_WRITE_BIAS   = 8'd34;

    ///////////////////////////////
    // field lsb positions
    ///////////////////////////////
    // word 0
    localparam int OPCODE_LSB      = 0;
    localparam int IN_CHAN_LSB     = 8;
    localparam int OUT_CHAN_LSB    = 20;
    // word 1, square map
    localparam int OFMAP_DIM_LSB   = 2;
    // word 2
    localparam int KERNEL_CODE_LSB = 0;

    // status word values
    localparam ctrl_word_t STATUS_WEIGHT_DONE = 32'd1;
    localparam ctrl_word_t STATUS_OUTPUT_DONE = 32'hFFFF_FFFF;

endpackage

// File: src/cnn_fsm_pkg.sv
package cnn_fsm_pkg;

    // input map row loader
    typedef enum logic [2:0] {
        IFM_IDLE,
        IFM_WAIT_ROW,
        IFM_LOAD_ROW,
        IFM_COMPUTE,
        IFM_WAIT_SLIDE,
        IFM_LOAD_SLIDE
    } ifmaps_state_e;

    // per-filter weight fetch
    typedef enum logic [2:0] {
        WL_IDLE,
        WL_START,
        WL_FETCH_A,
        WL_PAIR_B,
        WL_LOAD
    } weight_state_e;

    // host weight write
    typedef enum logic [1:0] {
        WW_IDLE,
        WW_START,
        WW_WAIT,
        WW_DONE
    } write_state_e;

    // kernel rows, 1 to 5
    typedef logic [2:0] kernel_rows_t;

    // one-hot kernel size codes
    localparam logic [4:0] KSIZE_1 = 5'b00001;
    localparam logic [4:0] KSIZE_2 = 5'b00010;
    localparam logic [4:0] KSIZE_3 = 5'b00100;
    localparam logic [4:0] KSIZE_4 = 5'b01000;
    localparam logic [4:0] KSIZE_5 = 5'b10000;

endpackage

// File: src/inst_decode.sv
module inst_decode #(
    parameter int MAC_NUM = 256
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  cnn_isa_pkg::ctrl_word_t   ctrl0_i,
    input  cnn_isa_pkg::ctrl_word_t   ctrl1_i,
    input  cnn_isa_pkg::ctrl_word_t   ctrl2_i,
    output logic                      compute_o,
    output logic                      write_weight_o,
    output logic                      new_inst_o,
    output cnn_fsm_pkg::kernel_rows_t kernel_rows_o,
    output cnn_isa_pkg::chan_size_t   out_channels_o,
    output cnn_isa_pkg::ofmap_dim_t   ofmap_width_o,
    output logic [MAC_NUM-1:0]        mac_enable_o
);

    cnn_isa_pkg::opcode_t      opcode;
    cnn_isa_pkg::chan_size_t   in_channels;
    cnn_isa_pkg::kernel_code_t kernel_code;
    logic                      compute_q;
    logic                      write_weight_q;

    ///////////////////////////////
    // field extraction
    ///////////////////////////////
    assign opcode         = ctrl0_i[cnn_isa_pkg::OPCODE_LSB +: $bits(cnn_isa_pkg::opcode_t)];
    assign in_channels    = ctrl0_i[cnn_isa_pkg::IN_CHAN_LSB +: $bits(cnn_isa_pkg::chan_size_t)];
    assign out_channels_o = ctrl0_i[cnn_isa_pkg::OUT_CHAN_LSB +: $bits(cnn_isa_pkg::chan_size_t)];
    assign ofmap_width_o  = ctrl1_i[cnn_isa_pkg::OFMAP_DIM_LSB +: $bits(cnn_isa_pkg::ofmap_dim_t)];
    assign kernel_code    = ctrl2_i[cnn_isa_pkg::KERNEL_CODE_LSB +:
                                    $bits(cnn_isa_pkg::kernel_code_t)];

    assign compute_o      = (opcode == cnn_isa_pkg::OP_COMPUTE);
    assign write_weight_o = (opcode == cnn_isa_pkg::OP_WRITE_WEIGHT);

    // rising edge of either opcode level
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            compute_q      <= 1'b0;
            write_weight_q <= 1'b0;
        end else begin
            compute_q      <= compute_o;
            write_weight_q <= write_weight_o;
        end
    end

    assign new_inst_o = (compute_o && !compute_q) || (write_weight_o && !write_weight_q);

    // non one-hot codes fall back to a single row
    always_comb begin
        case (kernel_code)
            cnn_fsm_pkg::KSIZE_2: kernel_rows_o = 3'd2;
            cnn_fsm_pkg::KSIZE_3: kernel_rows_o = 3'd3;
            cnn_fsm_pkg::KSIZE_4: kernel_rows_o = 3'd4;
            cnn_fsm_pkg::KSIZE_5: kernel_rows_o = 3'd5;
            default:              kernel_rows_o = 3'd1;
        endcase
    end

    // thermometer mask, low lanes first
    always_comb begin
        for (int n = 0; n < MAC_NUM; n++) begin
            mac_enable_o[n] = (n < in_channels);
        end
    end

endmodule

// File: src/weight_write_seq.sv
module weight_write_seq (
    input  logic clk,
    input  logic rst_n,
    input  logic write_weight_i,
    input  logic write_weight_done_i,
    output logic weight_write_en_o,
    output logic transfer_start_o
);

    cnn_fsm_pkg::write_state_e state;

    // opcode drop returns to idle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cnn_fsm_pkg::WW_IDLE;
        end else if (!write_weight_i) begin
            state <= cnn_fsm_pkg::WW_IDLE;
        end else begin
            case (state)
                cnn_fsm_pkg::WW_IDLE: begin
                    state <= cnn_fsm_pkg::WW_START;
                end
                cnn_fsm_pkg::WW_START: begin
                    state <= cnn_fsm_pkg::WW_WAIT;
                end
                cnn_fsm_pkg::WW_WAIT: begin
                    if (write_weight_done_i) begin
                        state <= cnn_fsm_pkg::WW_DONE;
                    end
                end
                // held until the opcode changes
                cnn_fsm_pkg::WW_DONE: begin
                    state <= cnn_fsm_pkg::WW_DONE;
                end
                default: begin
                    state <= cnn_fsm_pkg::WW_IDLE;
                end
            endcase
        end
    end

    assign weight_write_en_o = (state != cnn_fsm_pkg::WW_IDLE);
    assign transfer_start_o  = (state == cnn_fsm_pkg::WW_START);

endmodule

// File: src/ifmaps_seq.sv
module ifmaps_seq (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      compute_i,
    input  logic                      ifmaps_empty_i,
    input  logic                      pass_done_i,
    input  cnn_fsm_pkg::kernel_rows_t kernel_rows_i,
    input  cnn_isa_pkg::ofmap_dim_t   ofmap_width_i,
    output logic                      load_ifmaps_o,
    output logic                      compute_phase_o,
    output logic                      layer_finish_o
);

    cnn_fsm_pkg::ifmaps_state_e state;
    cnn_isa_pkg::ofmap_dim_t    row_cnt;
    cnn_isa_pkg::ofmap_dim_t    col_cnt;
    cnn_fsm_pkg::kernel_rows_t  loaded_cnt;
    logic                       layer_done_q;
    logic                       last_col;
    logic                       last_row;

    assign last_col = (col_cnt == ofmap_width_i - 9'd1);
    assign last_row = (row_cnt == ofmap_width_i - 9'd1);

    ///////////////////////////////
    // row load and slide FSM
    ///////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= cnn_fsm_pkg::IFM_IDLE;
            row_cnt    <= '0;
            col_cnt    <= '0;
            loaded_cnt <= '0;
        end else if (!compute_i) begin
            state <= cnn_fsm_pkg::IFM_IDLE;
        end else begin
            case (state)
                cnn_fsm_pkg::IFM_IDLE: begin
                    row_cnt    <= '0;
                    col_cnt    <= '0;
                    loaded_cnt <= '0;
                    // one layer per compute opcode
                    if (!layer_done_q) begin
                        state <= cnn_fsm_pkg::IFM_WAIT_ROW;
                    end
                end
                cnn_fsm_pkg::IFM_WAIT_ROW: begin
                    if (!ifmaps_empty_i) begin
                        state <= cnn_fsm_pkg::IFM_LOAD_ROW;
                    end
                end
                cnn_fsm_pkg::IFM_LOAD_ROW: begin
                    loaded_cnt <= loaded_cnt + 3'd1;
                    if (loaded_cnt + 3'd1 == kernel_rows_i) begin
                        state <= cnn_fsm_pkg::IFM_COMPUTE;
                    end else begin
                        state <= cnn_fsm_pkg::IFM_WAIT_ROW;
                    end
                end
                cnn_fsm_pkg::IFM_COMPUTE: begin
                    if (pass_done_i) begin
                        if (last_col && last_row) begin
                            state <= cnn_fsm_pkg::IFM_IDLE;
                        end else if (last_col) begin
                            // next output row needs a fresh window
                            col_cnt    <= '0;
                            row_cnt    <= row_cnt + 9'd1;
                            loaded_cnt <= '0;
                            state      <= cnn_fsm_pkg::IFM_WAIT_ROW;
                        end else begin
                            col_cnt <= col_cnt + 9'd1;
                            state   <= cnn_fsm_pkg::IFM_WAIT_SLIDE;
                        end
                    end
                end
                cnn_fsm_pkg::IFM_WAIT_SLIDE: begin
                    if (!ifmaps_empty_i) begin
                        state <= cnn_fsm_pkg::IFM_LOAD_SLIDE;
                    end
                end
                cnn_fsm_pkg::IFM_LOAD_SLIDE: begin
                    state <= cnn_fsm_pkg::IFM_COMPUTE;
                end
                default: begin
                    state <= cnn_fsm_pkg::IFM_IDLE;
                end
            endcase
        end
    end

    // cleared once the opcode drops
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_done_q <= 1'b0;
        end else if (!compute_i) begin
            layer_done_q <= 1'b0;
        end else if (layer_finish_o) begin
            layer_done_q <= 1'b1;
        end
    end

    assign load_ifmaps_o   = (state == cnn_fsm_pkg::IFM_LOAD_ROW) ||
                             (state == cnn_fsm_pkg::IFM_LOAD_SLIDE);
    assign compute_phase_o = (state == cnn_fsm_pkg::IFM_COMPUTE);
    assign layer_finish_o  = compute_phase_o && pass_done_i && last_col && last_row;

endmodule

// File: src/weight_load_seq.sv
module weight_load_seq (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      compute_i,
    input  logic                      compute_phase_i,
    input  logic                      weight_valid_i,
    input  cnn_fsm_pkg::kernel_rows_t kernel_rows_i,
    input  cnn_isa_pkg::chan_size_t   out_channels_i,
    output logic                      transfer_start_o,
    output logic                      load_weight_preload_o,
    output logic                      load_weight_o,
    output logic                      weight_port_sel_o,
    output logic                      weight_addr_inc1_o,
    output logic                      weight_addr_inc2_o,
    output logic                      pass_done_o
);

    cnn_fsm_pkg::weight_state_e state;
    cnn_fsm_pkg::kernel_rows_t  row_cnt;
    cnn_fsm_pkg::kernel_rows_t  row_next;
    cnn_isa_pkg::chan_size_t    filter_cnt;
    logic                       fetch_a;
    logic                       rows_done;
    logic                       last_filter;

    assign row_next    = row_cnt + 3'd1;
    assign rows_done   = (row_next == kernel_rows_i);
    assign last_filter = (filter_cnt + 12'd1 == out_channels_i);
    // port A word accepted this cycle
    assign fetch_a     = (state == cnn_fsm_pkg::WL_FETCH_A) && weight_valid_i;

    ///////////////////////////////
    // filter loop FSM
    ///////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= cnn_fsm_pkg::WL_IDLE;
            row_cnt    <= '0;
            filter_cnt <= '0;
        end else if (!compute_i) begin
            state <= cnn_fsm_pkg::WL_IDLE;
        end else begin
            case (state)
                cnn_fsm_pkg::WL_IDLE: begin
                    filter_cnt <= '0;
                    if (compute_phase_i) begin
                        state <= cnn_fsm_pkg::WL_START;
                    end
                end
                cnn_fsm_pkg::WL_START: begin
                    row_cnt <= '0;
                    state   <= cnn_fsm_pkg::WL_FETCH_A;
                end
                cnn_fsm_pkg::WL_FETCH_A: begin
                    if (weight_valid_i) begin
                        row_cnt <= row_next;
                        state   <= rows_done ? cnn_fsm_pkg::WL_LOAD : cnn_fsm_pkg::WL_PAIR_B;
                    end
                end
                // port B row needs no valid wait
                cnn_fsm_pkg::WL_PAIR_B: begin
                    row_cnt <= row_next;
                    state   <= rows_done ? cnn_fsm_pkg::WL_LOAD : cnn_fsm_pkg::WL_FETCH_A;
                end
                cnn_fsm_pkg::WL_LOAD: begin
                    row_cnt    <= '0;
                    filter_cnt <= filter_cnt + 12'd1;
                    state      <= last_filter ? cnn_fsm_pkg::WL_IDLE : cnn_fsm_pkg::WL_FETCH_A;
                end
                default: begin
                    state <= cnn_fsm_pkg::WL_IDLE;
                end
            endcase
        end
    end

    assign transfer_start_o      = (state == cnn_fsm_pkg::WL_START);
    assign weight_port_sel_o     = (state == cnn_fsm_pkg::WL_PAIR_B);
    assign load_weight_preload_o = fetch_a || weight_port_sel_o;
    assign load_weight_o         = (state == cnn_fsm_pkg::WL_LOAD);
    assign pass_done_o           = load_weight_o && last_filter;

    // A+B pair advances by two, a lone final A by one
    assign weight_addr_inc2_o = weight_port_sel_o;
    assign weight_addr_inc1_o = fetch_a && rows_done;

endmodule

// File: src/host_status.sv
module host_status (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    new_inst_i,
    input  logic                    write_weight_done_i,
    input  logic                    output_done_i,
    input  logic                    layer_finish_i,
    output cnn_isa_pkg::ctrl_word_t status_o,
    output logic                    axis_en_o
);

    ///////////////////////////////
    // status word
    ///////////////////////////////
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            status_o <= '0;
        end else if (write_weight_done_i) begin
            status_o <= cnn_isa_pkg::STATUS_WEIGHT_DONE;
        end else if (output_done_i) begin
            status_o <= cnn_isa_pkg::STATUS_OUTPUT_DONE;
        end else if (new_inst_i) begin
            // host sees a cleared word once a new opcode lands
            status_o <= '0;
        end
    end

    // stream enable, open from the opcode edge to the end of the job
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            axis_en_o <= 1'b0;
        end else if (layer_finish_i || write_weight_done_i) begin
            axis_en_o <= 1'b0;
        end else if (new_inst_i) begin
            axis_en_o <= 1'b1;
        end
    end

endmodule

// File: src/cnn_ctrl_top.sv
module cnn_ctrl_top #(
    parameter int MAC_NUM = 256
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  cnn_isa_pkg::ctrl_word_t ctrl0_i,
    input  cnn_isa_pkg::ctrl_word_t ctrl1_i,
    input  cnn_isa_pkg::ctrl_word_t ctrl2_i,
    input  logic                    weight_valid_i,
    input  logic                    ifmaps_empty_i,
    input  logic                    write_weight_done_i,
    input  logic                    output_done_i,
    output logic                    layer_finish_o,
    output cnn_isa_pkg::ctrl_word_t status_o,
    output logic                    axis_en_o,
    output logic [MAC_NUM-1:0]      mac_enable_o,
    output logic                    load_ifmaps_o,
    output logic                    load_weight_preload_o,
    output logic                    load_weight_o,
    output logic                    weight_port_sel_o,
    output logic                    weight_addr_inc1_o,
    output logic                    weight_addr_inc2_o,
    output logic                    weight_transfer_start_o,
    output logic                    weight_write_en_o
);

    logic                      compute;
    logic                      write_weight;
    logic                      new_inst;
    cnn_fsm_pkg::kernel_rows_t kernel_rows;
    cnn_isa_pkg::chan_size_t   out_channels;
    cnn_isa_pkg::ofmap_dim_t   ofmap_width;
    logic                      compute_phase;
    logic                      pass_done;
    logic                      write_start;
    logic                      fetch_start;

    ///////////////////////////////
    // decode
    ///////////////////////////////
    inst_decode #(
        .MAC_NUM(MAC_NUM)
    ) u_inst_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .ctrl0_i       (ctrl0_i),
        .ctrl1_i       (ctrl1_i),
        .ctrl2_i       (ctrl2_i),
        .compute_o     (compute),
        .write_weight_o(write_weight),
        .new_inst_o    (new_inst),
        .kernel_rows_o (kernel_rows),
        .out_channels_o(out_channels),
        .ofmap_width_o (ofmap_width),
        .mac_enable_o  (mac_enable_o)
    );

    ///////////////////////////////
    // sequencers
    ///////////////////////////////
    weight_write_seq u_weight_write_seq (
        .clk                (clk),
        .rst_n              (rst_n),
        .write_weight_i     (write_weight),
        .write_weight_done_i(write_weight_done_i),
        .weight_write_en_o  (weight_write_en_o),
        .transfer_start_o   (write_start)
    );

    ifmaps_seq u_ifmaps_seq (
        .clk            (clk),
        .rst_n          (rst_n),
        .compute_i      (compute),
        .ifmaps_empty_i (ifmaps_empty_i),
        .pass_done_i    (pass_done),
        .kernel_rows_i  (kernel_rows),
        .ofmap_width_i  (ofmap_width),
        .load_ifmaps_o  (load_ifmaps_o),
        .compute_phase_o(compute_phase),
        .layer_finish_o (layer_finish_o)
    );

    weight_load_seq u_weight_load_seq (
        .clk                  (clk),
        .rst_n                (rst_n),
        .compute_i            (compute),
        .compute_phase_i      (compute_phase),
        .weight_valid_i       (weight_valid_i),
        .kernel_rows_i        (kernel_rows),
        .out_channels_i       (out_channels),
        .transfer_start_o     (fetch_start),
        .load_weight_preload_o(load_weight_preload_o),
        .load_weight_o        (load_weight_o),
        .weight_port_sel_o    (weight_port_sel_o),
        .weight_addr_inc1_o   (weight_addr_inc1_o),
        .weight_addr_inc2_o   (weight_addr_inc2_o),
        .pass_done_o          (pass_done)
    );

    // both sequencers restart the BRAM address
    assign weight_transfer_start_o = write_start | fetch_start;

    host_status u_host_status (
        .clk                (clk),
        .rst_n              (rst_n),
        .new_inst_i         (new_inst),
        .write_weight_done_i(write_weight_done_i),
        .output_done_i      (output_done_i),
        .layer_finish_i     (layer_finish_o),
        .status_o           (status_o),
        .axis_en_o          (axis_en_o)
    );

endmodule

// File: dv/cnn_ctrl_tb.sv
module cnn_ctrl_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAC_NUM       = 256;
    localparam int LAYER_TIMEOUT = 20000;

    logic                    clk = 1'b0;
    logic                    rst_n;
    cnn_isa_pkg::ctrl_word_t ctrl0_i;
    cnn_isa_pkg::ctrl_word_t ctrl1_i;
    cnn_isa_pkg::ctrl_word_t ctrl2_i;
    logic                    weight_valid_i;
    logic                    ifmaps_empty_i;
    logic                    write_weight_done_i;
    logic                    output_done_i;
    logic                    layer_finish_o;
    cnn_isa_pkg::ctrl_word_t status_o;
    logic                    axis_en_o;
    logic [MAC_NUM-1:0]      mac_enable_o;
    logic                    load_ifmaps_o;
    logic                    load_weight_preload_o;
    logic                    load_weight_o;
    logic                    weight_port_sel_o;
    logic                    weight_addr_inc1_o;
    logic                    weight_addr_inc2_o;
    logic                    weight_transfer_start_o;
    logic                    weight_write_en_o;

    int          errors = 0;
    int          layers = 0;
    bit          aborted = 1'b0;
    bit          expect_wen = 1'b0;
    int          exp_rows = 1;
    int unsigned pick_seed = 92;
    int unsigned stall_seed;
    int unsigned edge_ch[5] = '{0, 255, 256, 257, 4095};
    // pulse counters, never cleared
    int          ifm_cnt = 0;
    int          wt_cnt = 0;
    int          fin_cnt = 0;
    int          start_cnt = 0;
    int          preload_since = 0;
    int          addr_since = 0;
    // previous cycle copies for the status rules
    logic        wwd_q;
    logic        odone_q;
    logic        edge_q;
    logic        cmp_q;
    logic        ww_q;

    always #10 clk = ~clk;

    cnn_ctrl_top #(.MAC_NUM(MAC_NUM)) DUT (.*);

    function automatic int unsigned lcg_step(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // value in 0 .. range-1 from the stimulus stream
    function int unsigned random_below(input int unsigned range);
        pick_seed = lcg_step(pick_seed);
        return (pick_seed >> 16) % range;
    endfunction

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        errors++;
        $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    endtask

    task automatic plain_fail(input string msg);
        errors++;
        $display("failure at %0t: %s", $time, msg);
    endtask

    //////////////////////////////
    // protocol rules
    //////////////////////////////
    // port B row follows an accepted port A row
    assert property (@(posedge clk) disable iff (!rst_n)
        weight_port_sel_o |-> $past(load_weight_preload_o && !weight_port_sel_o))
        else plain_fail("port B fetch not preceded by a port A fetch");

    // random back-pressure on the FIFO and the weight BRAM
    initial begin
        ifmaps_empty_i = 1'b1;
        weight_valid_i = 1'b0;
        stall_seed     = lcg_step(32'd92);
        forever begin
            @(negedge clk);
            stall_seed     = lcg_step(stall_seed);
            ifmaps_empty_i = (stall_seed[18:17] == 2'b00);
            weight_valid_i = (stall_seed[21:20] != 2'b00);
        end
    end

    // pulse counts, rows and address steps per filter
    always @(posedge clk) begin
        if (load_ifmaps_o) begin
            ifm_cnt++;
        end
        if (layer_finish_o) begin
            fin_cnt++;
        end
        if (weight_transfer_start_o) begin
            start_cnt++;
        end
        if (expect_wen) begin
            assert (weight_write_en_o) else value_error("weight_write_en_o", 0, 1);
        end
        if (load_weight_o) begin
            wt_cnt++;
            assert (preload_since == exp_rows)
                else value_error("load_weight_preload_o count", preload_since, exp_rows);
            assert (addr_since == exp_rows)
                else value_error("weight address steps", addr_since, exp_rows);
            preload_since = 0;
            addr_since    = 0;
        end else begin
            if (load_weight_preload_o) begin
                preload_since++;
            end
            // a pair steps by two, a lone row by one
            if (weight_addr_inc2_o) begin
                addr_since += 2;
            end
            if (weight_addr_inc1_o) begin
                addr_since++;
            end
        end
    end

    // status one clock after done, output done or an opcode edge
    always @(posedge clk) begin
        if (!rst_n) begin
            wwd_q   <= 1'b0;
            odone_q <= 1'b0;
            edge_q  <= 1'b0;
            cmp_q   <= 1'b0;
            ww_q    <= 1'b0;
        end else begin
            if (wwd_q) begin
                assert (status_o == cnn_isa_pkg::STATUS_WEIGHT_DONE)
                    else value_error("status_o", status_o, cnn_isa_pkg::STATUS_WEIGHT_DONE);
                assert (!axis_en_o) else value_error("axis_en_o", axis_en_o, 0);
            end else if (odone_q) begin
                assert (status_o == cnn_isa_pkg::STATUS_OUTPUT_DONE)
                    else value_error("status_o", status_o, cnn_isa_pkg::STATUS_OUTPUT_DONE);
            end else if (edge_q) begin
                assert (status_o == 32'd0) else value_error("status_o", status_o, 0);
            end
            wwd_q   <= write_weight_done_i;
            odone_q <= output_done_i;
            edge_q  <= (ctrl0_i[7:0] == cnn_isa_pkg::OP_COMPUTE && !cmp_q) ||
                       (ctrl0_i[7:0] == cnn_isa_pkg::OP_WRITE_WEIGHT && !ww_q);
            cmp_q   <= (ctrl0_i[7:0] == cnn_isa_pkg::OP_COMPUTE);
            ww_q    <= (ctrl0_i[7:0] == cnn_isa_pkg::OP_WRITE_WEIGHT);
        end
    end

    task automatic check_zero(input string name, input logic [31:0] value);
        assert (value == 32'd0) else value_error(name, value, 32'd0);
    endtask

    task automatic check_idle();
        check_zero("layer_finish_o", layer_finish_o);
        check_zero("status_o", status_o);
        check_zero("axis_en_o", axis_en_o);
        check_zero("mac_enable_o ones", $countones(mac_enable_o));
        check_zero("load_ifmaps_o", load_ifmaps_o);
        check_zero("load_weight_preload_o", load_weight_preload_o);
        check_zero("load_weight_o", load_weight_o);
        check_zero("weight_port_sel_o", weight_port_sel_o);
        check_zero("weight_addr_inc1_o", weight_addr_inc1_o);
        check_zero("weight_addr_inc2_o", weight_addr_inc2_o);
        check_zero("weight_transfer_start_o", weight_transfer_start_o);
        check_zero("weight_write_en_o", weight_write_en_o);
    endtask

    // low lanes enabled up to the channel count
    task automatic check_mac(input int unsigned in_ch);
        int unsigned        ones;
        logic [MAC_NUM-1:0] exp_mask;
        ones     = (in_ch < MAC_NUM) ? in_ch : MAC_NUM;
        exp_mask = ~({MAC_NUM{1'b1}} << ones);
        @(posedge clk);
        assert ($countones(mac_enable_o) == ones)
            else value_error("mac_enable_o ones", $countones(mac_enable_o), ones);
        assert (mac_enable_o == exp_mask) else plain_fail("mac_enable_o ones not in low lanes");
    endtask

    task automatic write_weight_test();
        int base_start;
        base_start = start_cnt;
        @(negedge clk);
        ctrl0_i = {24'd0, cnn_isa_pkg::OP_WRITE_WEIGHT};
        @(negedge clk);
        expect_wen = 1'b1;
        assert (axis_en_o) else value_error("axis_en_o", axis_en_o, 1);
        repeat (1 + random_below(4)) @(negedge clk);
        write_weight_done_i = 1'b1;
        @(negedge clk);
        write_weight_done_i = 1'b0;
        repeat (3) @(negedge clk);
        assert (start_cnt - base_start == 1)
            else value_error("weight_transfer_start_o pulses", start_cnt - base_start, 1);
        // opcode change releases the write enable
        expect_wen = 1'b0;
        ctrl0_i    = '0;
        repeat (2) @(negedge clk);
        assert (!weight_write_en_o) else value_error("weight_write_en_o", weight_write_en_o, 0);
    endtask

    //////////////////////////////
    // one compute layer
    //////////////////////////////
    task automatic run_layer(input logic [4:0] kcode, input int unsigned rows);
        int unsigned width;
        int unsigned out_ch;
        int unsigned in_ch;
        int          base_ifm;
        int          base_wt;
        int          base_fin;
        int          cycles;
        width    = 1 + random_below(4);
        out_ch   = 1 + random_below(3);
        in_ch    = random_below(400);
        base_ifm = ifm_cnt;
        base_wt  = wt_cnt;
        base_fin = fin_cnt;
        exp_rows = rows;
        @(negedge clk);
        ctrl0_i = {out_ch[11:0], in_ch[11:0], cnn_isa_pkg::OP_COMPUTE};
        ctrl1_i = {21'd0, width[8:0], 2'b00};
        ctrl2_i = {27'd0, kcode};
        check_mac(in_ch);
        cycles = 0;
        while (fin_cnt == base_fin && cycles < LAYER_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (fin_cnt == base_fin) begin
            plain_fail("timeout while waiting for layer_finish_o");
            aborted = 1'b1;
            return;
        end
        // same opcode must not start another layer
        repeat (8) @(negedge clk);
        assert (ifm_cnt - base_ifm == width * (rows + width - 1))
            else value_error("load_ifmaps_o pulses", ifm_cnt - base_ifm,
                             width * (rows + width - 1));
        assert (wt_cnt - base_wt == out_ch * width * width)
            else value_error("load_weight_o pulses", wt_cnt - base_wt, out_ch * width * width);
        assert (fin_cnt - base_fin == 1)
            else value_error("layer_finish_o pulses", fin_cnt - base_fin, 1);
        assert (!axis_en_o) else value_error("axis_en_o", axis_en_o, 0);
        output_done_i = 1'b1;
        @(negedge clk);
        output_done_i = 1'b0;
        ctrl0_i       = '0;
        repeat (2) @(negedge clk);
        layers++;
    endtask

    initial begin
        rst_n               = 1'b0;
        ctrl0_i             = '0;
        ctrl1_i             = '0;
        ctrl2_i             = '0;
        write_weight_done_i = 1'b0;
        output_done_i       = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        check_idle();
        write_weight_test();
        foreach (edge_ch[i]) begin
            @(negedge clk);
            ctrl0_i = {12'd0, edge_ch[i][11:0], 8'd0};
            check_mac(edge_ch[i]);
        end
        for (int k = 0; k < 5 && !aborted; k++) begin
            run_layer(5'b00001 << k, k + 1);
        end
        // random kernels then a code that is not one-hot
        for (int n = 0; n < 4 && !aborted; n++) begin
            int unsigned kidx;
            kidx = random_below(5);
            run_layer(5'b00001 << kidx, kidx + 1);
        end
        if (!aborted) begin
            run_layer(5'b00110, 1);
        end
        $display("errors: %0d, layers run: %0d", errors, layers);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: build.f
src/cnn_isa_pkg.sv
src/cnn_fsm_pkg.sv
src/inst_decode.sv
src/weight_write_seq.sv
src/ifmaps_seq.sv
src/weight_load_seq.sv
src/host_status.sv
src/cnn_ctrl_top.sv
dv/cnn_ctrl_tb.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f build.f --top-module cnn_ctrl_tb \
    -o cnn_ctrl_sim > build.log 2>&1 || { cat build.log; echo "build error"; exit 1; }
./obj_dir/cnn_ctrl_sim > sim.log 2>&1
cat sim.log
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
